// ==== logic/mem_path_pkg.sv ====
package mem_path_pkg;

// bus widths
localparam int ADDR_W = 32;
localparam int DATA_W = 32;
localparam int STRB_W = DATA_W / 8;

// bank geometry
// word index starts above the byte offset
localparam int IDX_LSB      = 2;
localparam int WORD_IDX_W   = 14;
localparam int BANK_WORDS   = 1 << WORD_IDX_W;
localparam int BANK_SEL_BIT = 16;

// both banks sit below this address
localparam logic [ADDR_W - 1:0] REGION_LIMIT = 32'h0002_0000;

typedef logic [ADDR_W - 1:0] addr_t;
typedef logic [DATA_W - 1:0] data_t;
typedef logic [STRB_W - 1:0] strb_t;

// fault codes returned with every response
typedef enum logic [1:0] {
    FAULT_NONE       = 2'd0,
    FAULT_MISALIGNED = 2'd1,
    FAULT_ACCESS     = 2'd2
} fault_t;

endpackage

// ==== logic/mem_req_if.sv ====
`timescale 1ns/1ns

// checked request, one strobe per item
interface mem_req_if;

logic                  valid;
logic                  write;
mem_path_pkg::addr_t   addr;
mem_path_pkg::strb_t   strb;
mem_path_pkg::data_t   wdata;
mem_path_pkg::fault_t  fault;

modport source (
    output valid,
    output write,
    output addr,
    output strb,
    output wdata,
    output fault
);

modport sink (
    input  valid,
    input  write,
    input  addr,
    input  strb,
    input  wdata,
    input  fault
);

endinterface

// ==== logic/bank_rsp_if.sv ====
`timescale 1ns/1ns

// raw bank results plus the tags that travel with them
interface bank_rsp_if;

logic                  valid;
logic                  write;
logic                  bank;
mem_path_pkg::data_t   rdata0;
mem_path_pkg::data_t   rdata1;
mem_path_pkg::fault_t  fault;

modport source (
    output valid,
    output write,
    output bank,
    output rdata0,
    output rdata1,
    output fault
);

modport sink (
    input  valid,
    input  write,
    input  bank,
    input  rdata0,
    input  rdata1,
    input  fault
);

endinterface

// ==== logic/access_check.sv ====
`timescale 1ns/1ns

module access_check (
    input                         clk,
    input                         rst,
    input                         req_valid,
    input                         req_write,
    input  mem_path_pkg::addr_t   req_addr,
    input  mem_path_pkg::strb_t   req_strb,
    input  mem_path_pkg::data_t   req_wdata,
    mem_req_if.source             req
);

logic                  misaligned;
logic                  out_of_range;
mem_path_pkg::fault_t  fault;

assign misaligned   = |req_addr[mem_path_pkg::IDX_LSB - 1:0];
assign out_of_range = req_addr >= mem_path_pkg::REGION_LIMIT;

// misaligned takes priority over the region check
always_comb begin
    if (misaligned) begin
        fault = mem_path_pkg::FAULT_MISALIGNED;
    end
    else if (out_of_range) begin
        fault = mem_path_pkg::FAULT_ACCESS;
    end
    else begin
        fault = mem_path_pkg::FAULT_NONE;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        req.valid <= 1'b0;
    end
    else begin
        req.valid <= req_valid;
    end
end

// payload and fault code, no reset needed
always_ff @(posedge clk) begin
    req.write <= req_write;
    req.addr  <= req_addr;
    req.strb  <= req_strb;
    req.wdata <= req_wdata;
    req.fault <= fault;
end

endmodule

// ==== logic/sram_bank.sv ====
`timescale 1ns/1ns

module sram_bank (
    input                                        clk,
    input                                        en,
    input                                        we,
    input  logic [mem_path_pkg::WORD_IDX_W - 1:0] idx,
    input  mem_path_pkg::strb_t                  strb,
    input  mem_path_pkg::data_t                  wdata,
    output mem_path_pkg::data_t                  rdata
);

mem_path_pkg::data_t memory [mem_path_pkg::BANK_WORDS];

// one access per cycle, either a strobed write or a read
always_ff @(posedge clk) begin
    if (en) begin
        if (we) begin
            for (int i = 0; i < mem_path_pkg::STRB_W; i++) begin
                if (strb[i]) begin
                    memory[idx][8 * i +: 8] <= wdata[8 * i +: 8];
                end
            end
        end
        else begin
            rdata <= memory[idx];
        end
    end
end

endmodule

// ==== logic/bank_stage.sv ====
`timescale 1ns/1ns

module bank_stage (
    input                  clk,
    input                  rst,
    mem_req_if.sink        req,
    bank_rsp_if.source     rsp
);

logic                                   hit;
logic                                   sel;
logic                                   en_0;
logic                                   en_1;
logic [mem_path_pkg::WORD_IDX_W - 1:0]  idx;

// faulted requests never reach a bank
assign hit  = req.valid && (req.fault == mem_path_pkg::FAULT_NONE);
assign sel  = req.addr[mem_path_pkg::BANK_SEL_BIT];
assign en_0 = hit && !sel;
assign en_1 = hit && sel;
assign idx  = req.addr[mem_path_pkg::IDX_LSB +: mem_path_pkg::WORD_IDX_W];

sram_bank u_sram_0 (
    .clk   ( clk        ),
    .en    ( en_0       ),
    .we    ( req.write  ),
    .idx   ( idx        ),
    .strb  ( req.strb   ),
    .wdata ( req.wdata  ),
    .rdata ( rsp.rdata0 )
);

sram_bank u_sram_1 (
    .clk   ( clk        ),
    .en    ( en_1       ),
    .we    ( req.write  ),
    .idx   ( idx        ),
    .strb  ( req.strb   ),
    .wdata ( req.wdata  ),
    .rdata ( rsp.rdata1 )
);

always_ff @(posedge clk) begin
    if (rst) begin
        rsp.valid <= 1'b0;
    end
    else begin
        rsp.valid <= req.valid;
    end
end

// tags line up with the registered bank read
always_ff @(posedge clk) begin
    rsp.write <= req.write;
    rsp.bank  <= sel;
    rsp.fault <= req.fault;
end

endmodule

// ==== logic/resp_stage.sv ====
`timescale 1ns/1ns

module resp_stage (
    input                         clk,
    input                         rst,
    bank_rsp_if.sink              raw,
    output logic                  rsp_valid,
    output mem_path_pkg::data_t   rsp_rdata,
    output mem_path_pkg::fault_t  rsp_fault
);

logic                 has_data;
mem_path_pkg::data_t  bank_data;

// only a clean read returns data
assign has_data  = !raw.write && (raw.fault == mem_path_pkg::FAULT_NONE);
assign bank_data = raw.bank ? raw.rdata1 : raw.rdata0;

always_ff @(posedge clk) begin
    if (rst) begin
        rsp_valid <= 1'b0;
    end
    else begin
        rsp_valid <= raw.valid;
    end
end

always_ff @(posedge clk) begin
    rsp_rdata <= has_data ? bank_data : '0;
    rsp_fault <= raw.fault;
end

endmodule

// ==== logic/mem_path_top.sv ====
`timescale 1ns/1ns

module mem_path_top (
    input                         clk,
    input                         rst,

    // request
    input                         req_valid,
    input                         req_write,
    input  mem_path_pkg::addr_t   req_addr,
    input  mem_path_pkg::strb_t   req_strb,
    input  mem_path_pkg::data_t   req_wdata,

    // response, three cycles later
    output logic                  rsp_valid,
    output mem_path_pkg::data_t   rsp_rdata,
    output mem_path_pkg::fault_t  rsp_fault
);

mem_req_if  u_mem_req ();
bank_rsp_if u_bank_rsp ();

access_check u_access_check (
    .clk       ( clk        ),
    .rst       ( rst        ),
    .req_valid ( req_valid  ),
    .req_write ( req_write  ),
    .req_addr  ( req_addr   ),
    .req_strb  ( req_strb   ),
    .req_wdata ( req_wdata  ),
    .req       ( u_mem_req  )
);

bank_stage u_bank_stage (
    .clk       ( clk        ),
    .rst       ( rst        ),
    .req       ( u_mem_req  ),
    .rsp       ( u_bank_rsp )
);

resp_stage u_resp_stage (
    .clk       ( clk        ),
    .rst       ( rst        ),
    .raw       ( u_bank_rsp ),
    .rsp_valid ( rsp_valid  ),
    .rsp_rdata ( rsp_rdata  ),
    .rsp_fault ( rsp_fault  )
);

endmodule

// ==== include/tb_util.svh ====
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
localparam logic [15:0] LFSR_TAPS = 16'hB400;
localparam logic [15:0] LFSR_SEED = 16'd34767;

// one step, the caller takes bit 0 of the old state
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ LFSR_TAPS;
    end
    return next;
endfunction

// stops on the first mismatch
task automatic check_value(
    input string       what,
    input logic [31:0] got,
    input logic [31:0] exp
);
    if (got !== exp) begin
        $display("Verification failed");
        $fatal(1, "%s mismatch: got %h expected %h at %0t", what, got, exp, $time);
    end
endtask

`endif

// ==== bench/tb_mem_path.sv ====
`timescale 1ns/1ns

module tb_mem_path;

`include "tb_util.svh"

// test sizes
localparam int N_WINDOW       = 16;
localparam int N_PARTIAL      = 24;
localparam int N_FAULT_ROUNDS = 8;
localparam int N_MIX          = 200;

// fill, readback, partial writes and reads, fault rounds, mix
localparam int TOTAL_REQS = 2 * N_WINDOW + 2 * N_WINDOW + N_PARTIAL + 2 * N_WINDOW
                          + 6 * N_FAULT_ROUNDS + N_MIX;
localparam int CYCLE_LIMIT = 2 * TOTAL_REQS + 50;

logic                  clk;
logic                  rst;
logic                  req_valid;
logic                  req_write;
mem_path_pkg::addr_t   req_addr;
mem_path_pkg::strb_t   req_strb;
mem_path_pkg::data_t   req_wdata;
logic                  rsp_valid;
mem_path_pkg::data_t   rsp_rdata;
mem_path_pkg::fault_t  rsp_fault;

logic [15:0] lfsr_state;
int          cycle_count = 0;

// model of the 16-word window at the bottom of each bank
mem_path_pkg::data_t model_mem [2][N_WINDOW];

// expected responses in request order
string                 name_q  [$];
int                    due_q   [$];
mem_path_pkg::data_t   rdata_q [$];
mem_path_pkg::fault_t  fault_q [$];

mem_path_top i_mem_path_top (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .req_valid ( req_valid ),
    .req_write ( req_write ),
    .req_addr  ( req_addr  ),
    .req_strb  ( req_strb  ),
    .req_wdata ( req_wdata ),
    .rsp_valid ( rsp_valid ),
    .rsp_rdata ( rsp_rdata ),
    .rsp_fault ( rsp_fault )
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
        $display("Verification failed");
        $fatal(1, "timeout: the run went past %0d cycles", CYCLE_LIMIT);
    end
end

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value[i]   = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
endfunction

function automatic mem_path_pkg::addr_t window_addr(input logic bank, input int word);
    mem_path_pkg::addr_t addr;
    addr = '0;
    addr[16] = bank;
    addr[2 +: 4] = word[3:0];
    return addr;
endfunction

// misaligned is checked first
function automatic mem_path_pkg::fault_t expected_fault(input mem_path_pkg::addr_t addr);
    if (addr[1:0] != 2'b00) begin
        return mem_path_pkg::FAULT_MISALIGNED;
    end
    if (addr >= 32'h0002_0000) begin
        return mem_path_pkg::FAULT_ACCESS;
    end
    return mem_path_pkg::FAULT_NONE;
endfunction

function automatic mem_path_pkg::data_t merge_bytes(
    input mem_path_pkg::data_t old,
    input mem_path_pkg::data_t wdata,
    input mem_path_pkg::strb_t strb
);
    mem_path_pkg::data_t word;
    word = old;
    for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
            word[8 * i +: 8] = wdata[8 * i +: 8];
        end
    end
    return word;
endfunction

task automatic check_response();
    string name;
    int    due;
    if (rsp_valid === 1'b1) begin
        if (due_q.size() == 0) begin
            $display("Verification failed");
            $fatal(1, "a response came out with no request outstanding at cycle %0d",
                   cycle_count);
        end
        name = name_q.pop_front();
        due  = due_q.pop_front();
        check_value($sformatf("error [%s] latency", name), cycle_count, due);
        check_value($sformatf("error [%s] rdata", name), rsp_rdata, rdata_q.pop_front());
        check_value($sformatf("error [%s] fault", name), rsp_fault, fault_q.pop_front());
    end
    else if (due_q.size() > 0 && due_q[0] <= cycle_count) begin
        $display("Verification failed");
        $fatal(1, "the response for a %s request due at cycle %0d never came",
               name_q[0], due_q[0]);
    end
endtask

// checks outputs at the falling edge before new inputs go out
task automatic next_cycle();
    @(negedge clk);
    check_response();
endtask

task automatic idle();
    next_cycle();
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_strb  = '0;
    req_wdata = '0;
endtask

task automatic issue(
    input string                name,
    input logic                 write,
    input mem_path_pkg::addr_t  addr,
    input mem_path_pkg::strb_t  strb,
    input mem_path_pkg::data_t  wdata
);
    mem_path_pkg::fault_t  fault;
    mem_path_pkg::data_t   exp_rdata;
    logic                  bank;
    int                    word;
    next_cycle();
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_strb  = strb;
    req_wdata = wdata;
    fault     = expected_fault(addr);
    bank      = addr[16];
    word      = addr[5:2];
    exp_rdata = '0;
    if (fault == mem_path_pkg::FAULT_NONE) begin
        if (write) begin
            model_mem[bank][word] = merge_bytes(model_mem[bank][word], wdata, strb);
        end
        else begin
            exp_rdata = model_mem[bank][word];
        end
    end
    name_q.push_back(name);
    due_q.push_back(cycle_count + 3);
    rdata_q.push_back(exp_rdata);
    fault_q.push_back(fault);
endtask

task automatic drain();
    while (due_q.size() > 0) begin
        idle();
    end
    // nothing extra may follow
    repeat (2) idle();
endtask

task automatic read_window(input string name);
    for (int b = 0; b < 2; b++) begin
        for (int w = 0; w < N_WINDOW; w++) begin
            issue(name, 1'b0, window_addr(b, w), '0, '0);
        end
    end
endtask

task automatic fault_round();
    logic                 bank;
    int                   word;
    logic [1:0]           offset;
    mem_path_pkg::addr_t  base;
    bank   = random_bits(1);
    word   = random_bits(4);
    offset = random_bits(2);
    if (offset == 2'b00) begin
        offset = 2'b01;
    end
    base = window_addr(bank, word);
    issue("misaligned", 1'b1, base + offset, 4'hF, random_bits(32));
    issue("misaligned", 1'b0, base + offset, '0, '0);
    issue("misaligned check", 1'b0, base, '0, '0);
    // same bank index and word as base, one bit above the banks
    issue("access", 1'b1, 32'h0002_0000 | base, 4'hF, random_bits(32));
    issue("access", 1'b0, (32'h0002_0000 | random_bits(32)) & ~32'h3, '0, '0);
    issue("access check", 1'b0, base, '0, '0);
endtask

task automatic mix_request();
    logic [2:0]           kind;
    logic                 bank;
    int                   word;
    mem_path_pkg::addr_t  addr;
    kind = random_bits(3);
    bank = random_bits(1);
    word = random_bits(4);
    addr = window_addr(bank, word);
    if (kind <= 3) begin
        issue("mix read", 1'b0, addr, '0, '0);
    end
    else if (kind <= 5) begin
        issue("mix write", 1'b1, addr, random_bits(4), random_bits(32));
    end
    else if (kind == 6) begin
        issue("mix misaligned", random_bits(1), addr | 32'h1, random_bits(4), random_bits(32));
    end
    else begin
        issue("mix access", random_bits(1), 32'h0002_0000 | random_bits(32) & ~32'h3,
              random_bits(4), random_bits(32));
    end
endtask

initial begin
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_strb   = '0;
    req_wdata  = '0;
    lfsr_state = LFSR_SEED;

    repeat (4) begin
        @(negedge clk);
        check_value("error [reset] rsp_valid", rsp_valid, 1'b0);
    end
    rst = 1'b0;
    repeat (3) idle();

    for (int b = 0; b < 2; b++) begin
        for (int w = 0; w < N_WINDOW; w++) begin
            issue("fill", 1'b1, window_addr(b, w), 4'hF, random_bits(32));
        end
    end
    drain();
    read_window("readback");
    drain();

    for (int i = 0; i < N_PARTIAL; i++) begin
        issue("partial write", 1'b1, window_addr(random_bits(1), random_bits(4)),
              random_bits(4), random_bits(32));
    end
    read_window("partial read");
    drain();

    repeat (N_FAULT_ROUNDS) fault_round();
    drain();

    // back to back, one request every cycle
    repeat (N_MIX) mix_request();
    drain();

    $display("Verification passed");
    $finish;
end

endmodule

// ==== all.f ====
+incdir+include
logic/mem_path_pkg.sv
logic/mem_req_if.sv
logic/bank_rsp_if.sv
logic/access_check.sv
logic/sram_bank.sv
logic/bank_stage.sv
logic/resp_stage.sv
logic/mem_path_top.sv
bench/tb_mem_path.sv
